// File: logic/ball_motion.sv
`timescale 1ns/1ps

module ball_motion (
	input logic CLOCK_50_I,
	input logic system_resetn,
	input logic frame_step,
	input logic ball_enable,
	input logic new_game,
	input pong_pkg::speed_t ball_speed,
	input pong_pkg::direction_t serve_dir, // Direction after a miss
	input pong_pkg::coord_t paddle_x,
	output pong_pkg::object_pos_t ball,
	output logic hit,
	output logic miss
);

	import pong_pkg::*;

	direction_t dir;
	coord_t step;
	logic can_right, can_left, can_down, can_up;
	logic on_paddle;

	assign step = coord_t'(ball_speed);

	// A move is taken only if the whole ball stays on screen
	assign can_right = (ball.x + step) <= (screen_width - ball_size);
	assign can_left = ball.x >= step;
	assign can_down = (ball.y + step) <= (paddle_y - ball_size); // Paddle row is the floor
	assign can_up = ball.y >= step;

	// Both edges of the ball inside the paddle span
	assign on_paddle = (ball.x >= paddle_x)
		&& ((ball.x + ball_size) <= (paddle_x + paddle_width));

	always_ff @(posedge CLOCK_50_I or negedge system_resetn) begin
		if (!system_resetn) begin
			ball <= ball_start;
			dir <= '{right: 1'b1, down: 1'b1};
			hit <= 1'b0;
			miss <= 1'b0;
		end else begin
			hit <= 1'b0;
			miss <= 1'b0;
			if (new_game) begin
				ball <= ball_start;
				dir <= '{right: 1'b1, down: 1'b1};
			end else if (frame_step && ball_enable) begin
				// Horizontal axis
				if (dir.right) begin
					if (can_right) ball.x <= ball.x + step;
					else dir.right <= 1'b0; // Right wall
				end else begin
					if (can_left) ball.x <= ball.x - step;
					else dir.right <= 1'b1; // Left wall
				end

				// Vertical axis
				if (!dir.down) begin
					if (can_up) ball.y <= ball.y - step;
					else dir.down <= 1'b1; // Top wall
				end else if (can_down) begin
					ball.y <= ball.y + step;
				end else if (on_paddle) begin
					dir.down <= 1'b0;
					hit <= 1'b1;
				end else begin
					// Missed, so serve again from the start point
					miss <= 1'b1;
					ball <= ball_start;
					dir <= serve_dir;
				end
			end
		end
	end

endmodule

// File: logic/countdown_timer.sv
`timescale 1ns/1ps

module countdown_timer #(
	parameter int unsigned clocks_per_second = pong_pkg::clocks_per_second
) (
	input logic CLOCK_50_I,
	input logic system_resetn,
	input logic run, // High while the game is over
	output pong_pkg::bcd2_t time_left,
	output logic expired
);

	import pong_pkg::*;

	logic [31:0] div_count;
	logic tick;

	assign tick = (div_count == clocks_per_second - 1); // Last cycle of a second

	always_ff @(posedge CLOCK_50_I or negedge system_resetn) begin
		if (!system_resetn) begin
			div_count <= '0;
			time_left <= countdown_start;
			expired <= 1'b0;
		end else begin
			expired <= 1'b0;
			if (!run || expired) begin
				// Idle or just ran out, so park at the reload values
				div_count <= '0;
				time_left <= countdown_start;
			end else if (tick) begin
				div_count <= '0;
				if (time_left.ones == 4'd0) begin // Borrow from tens
					time_left.ones <= 4'd9;
					time_left.tens <= time_left.tens - 4'd1;
				end else begin
					time_left.ones <= time_left.ones - 4'd1;
				end
				expired <= (time_left.tens == 4'd0) && (time_left.ones == 4'd1); // Next is 00
			end else begin
				div_count <= div_count + 32'd1;
			end
		end
	end

endmodule

// File: logic/game_fsm.sv
`timescale 1ns/1ps

module game_fsm (
	input logic CLOCK_50_I,
	input logic system_resetn,
	input logic vsync,
	input logic miss,
	input pong_pkg::lives_t lives,
	input logic expired,
	output logic frame_step,
	output logic ball_enable,
	output logic game_end,
	output logic new_game,
	output logic game_over
);

	import pong_pkg::*;

	logic vsync_q; // Vsync level from the previous cycle

	// Frame step on the falling edge of vsync
	always_ff @(posedge CLOCK_50_I or negedge system_resetn) begin
		if (!system_resetn) begin
			vsync_q <= 1'b1; // No step if vsync is low out of reset
			frame_step <= 1'b0;
		end else begin
			vsync_q <= vsync;
			frame_step <= vsync_q & ~vsync;
		end
	end

	// Two states, game_over low is playing and high is over
	always_ff @(posedge CLOCK_50_I or negedge system_resetn) begin
		if (!system_resetn) begin
			game_over <= 1'b0;
			game_end <= 1'b0;
		end else begin
			game_end <= 1'b0;
			if (!game_over) begin
				// Lives still holds the old count while the miss pulse is up
				if (miss && lives == lives_t'(1)) begin
					game_over <= 1'b1;
					game_end <= 1'b1; // High score is recorded on this pulse
				end
			end else if (expired) begin
				game_over <= 1'b0;
			end
		end
	end

	assign ball_enable = ~game_over;

	// Same cycle as expired so everything restarts together at the next edge
	assign new_game = game_over & expired;

endmodule

// File: logic/paddle_motion.sv
`timescale 1ns/1ps

module paddle_motion (
	input logic CLOCK_50_I,
	input logic system_resetn,
	input logic frame_step,
	input logic move_right,
	input logic move_left,
	output pong_pkg::coord_t paddle_x
);

	import pong_pkg::*;

	always_ff @(posedge CLOCK_50_I or negedge system_resetn) begin
		if (!system_resetn) begin
			paddle_x <= paddle_start_x;
		end else if (frame_step) begin
			// Right wins when both buttons are held
			if (move_right) begin
				if (paddle_x < screen_width - paddle_width - paddle_step)
					paddle_x <= paddle_x + paddle_step; // Stops at 575
			end else if (move_left) begin
				if (paddle_x > paddle_step)
					paddle_x <= paddle_x - paddle_step; // Stops at 5
			end
		end
	end

endmodule

// File: logic/pong_core.sv
`timescale 1ns/1ps

module pong_core #(
	parameter int unsigned clocks_per_second = pong_pkg::clocks_per_second
) (
	input logic CLOCK_50_I,
	input logic system_resetn,
	input logic vsync,
	input logic move_right,
	input logic move_left,
	input pong_pkg::speed_t ball_speed,
	input pong_pkg::direction_t serve_dir,
	output pong_pkg::object_pos_t ball,
	output pong_pkg::coord_t paddle_x,
	output pong_pkg::bcd2_t score,
	output pong_pkg::lives_t lives,
	output pong_pkg::bcd2_t high_score,
	output pong_pkg::bcd2_t high_game_id,
	output logic game_over,
	output pong_pkg::bcd2_t time_left
);

	import pong_pkg::*;

	logic frame_step, ball_enable, game_end, new_game;
	logic hit, miss;
	logic expired;
	bcd2_t countdown; // Time left, routed to the output below

	game_fsm i_game_fsm (
		.CLOCK_50_I(CLOCK_50_I),
		.system_resetn(system_resetn),
		.vsync(vsync),
		.miss(miss),
		.lives(lives),
		.expired(expired),
		.frame_step(frame_step),
		.ball_enable(ball_enable),
		.game_end(game_end),
		.new_game(new_game),
		.game_over(game_over)
	);

	ball_motion i_ball_motion (
		.CLOCK_50_I(CLOCK_50_I),
		.system_resetn(system_resetn),
		.frame_step(frame_step),
		.ball_enable(ball_enable),
		.new_game(new_game),
		.ball_speed(ball_speed),
		.serve_dir(serve_dir),
		.paddle_x(paddle_x),
		.ball(ball),
		.hit(hit),
		.miss(miss)
	);

	paddle_motion i_paddle_motion (
		.CLOCK_50_I(CLOCK_50_I),
		.system_resetn(system_resetn),
		.frame_step(frame_step),
		.move_right(move_right),
		.move_left(move_left),
		.paddle_x(paddle_x)
	);

	score_keeper i_score_keeper (
		.CLOCK_50_I(CLOCK_50_I),
		.system_resetn(system_resetn),
		.hit(hit),
		.miss(miss),
		.game_end(game_end),
		.new_game(new_game),
		.score(score),
		.high_score(high_score),
		.high_game_id(high_game_id),
		.lives(lives)
	);

	// Runs only while the game is over
	countdown_timer #(
		.clocks_per_second(clocks_per_second)
	) i_countdown_timer (
		.CLOCK_50_I(CLOCK_50_I),
		.system_resetn(system_resetn),
		.run(game_over),
		.time_left(countdown),
		.expired(expired)
	);

	assign time_left = countdown;

endmodule

// File: logic/pong_pkg.sv
package pong_pkg;

	typedef logic [9:0] coord_t; // One screen coordinate
	typedef logic [2:0] speed_t; // Pixels per frame
	typedef logic [1:0] lives_t;

	// Two decimal digits, tens in the upper nibble
	typedef struct packed {
		logic [3:0] tens;
		logic [3:0] ones;
	} bcd2_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} object_pos_t;

	typedef struct packed {
		logic right;
		logic down;
	} direction_t;

	// Screen and object geometry
	localparam coord_t screen_width = 10'd640;
	localparam coord_t screen_height = 10'd480;
	localparam coord_t ball_size = 10'd10;
	localparam coord_t paddle_width = 10'd60;
	localparam coord_t paddle_height = 10'd5;
	localparam coord_t paddle_step = 10'd5;
	localparam coord_t bottom_margin = 10'd50;
	localparam coord_t paddle_y = screen_height - paddle_height - bottom_margin; // Row 425

	// Game rules
	localparam object_pos_t ball_start = '{x: 10'd200, y: 10'd50};
	localparam coord_t paddle_start_x = 10'd200;
	localparam lives_t start_lives = 2'd3;
	localparam bcd2_t countdown_start = '{tens: 4'd1, ones: 4'd5};
	localparam bcd2_t first_game_id = '{tens: 4'd0, ones: 4'd1};
	localparam int unsigned clocks_per_second = 50_000_000;

endpackage

// File: logic/score_keeper.sv
`timescale 1ns/1ps

module score_keeper (
	input logic CLOCK_50_I,
	input logic system_resetn,
	input logic hit,
	input logic miss,
	input logic game_end,
	input logic new_game,
	output pong_pkg::bcd2_t score,
	output pong_pkg::bcd2_t high_score,
	output pong_pkg::bcd2_t high_game_id,
	output pong_pkg::lives_t lives
);

	import pong_pkg::*;

	bcd2_t game_id; // Number of the game in progress

	// Decimal increment, 99 wraps to 00
	function automatic bcd2_t bcd_inc(input bcd2_t value);
		bcd2_t result;
		result = value;
		if (value.ones == 4'd9) begin
			result.ones = 4'd0;
			result.tens = (value.tens == 4'd9) ? 4'd0 : value.tens + 4'd1;
		end else begin
			result.ones = value.ones + 4'd1;
		end
		return result;
	endfunction

	always_ff @(posedge CLOCK_50_I or negedge system_resetn) begin
		if (!system_resetn) begin
			score <= '0;
			lives <= start_lives;
			high_score <= '0;
			high_game_id <= '0;
			game_id <= first_game_id;
		end else begin
			if (new_game) begin
				score <= '0;
				lives <= start_lives;
			end else begin
				if (hit) score <= bcd_inc(score);
				if (miss && lives != lives_t'(0)) lives <= lives - lives_t'(1);
			end

			if (game_end) begin
				// Tens sit in the upper nibble so a plain compare orders BCD
				if (score >= high_score) begin
					high_score <= score;
					high_game_id <= game_id;
				end
				game_id <= bcd_inc(game_id);
			end
		end
	end

endmodule

// File: pong_core.f
logic/pong_pkg.sv
logic/countdown_timer.sv
logic/game_fsm.sv
logic/ball_motion.sv
logic/paddle_motion.sv
logic/score_keeper.sv
logic/pong_core.sv
tests/pong_core_properties.sv
tests/pong_core_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f pong_core.f --top-module pong_core_tb -o pong_core_sim

out=$(./obj_dir/pong_core_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q ">>> PASS"; then
	exit 0
else
	exit 1
fi

// File: tests/pong_core_properties.sv
`timescale 1ns/1ps

module pong_core_properties (
	input logic CLOCK_50_I,
	input logic system_resetn,
	input pong_pkg::bcd2_t score,
	input pong_pkg::lives_t lives,
	input logic game_over,
	input pong_pkg::object_pos_t ball,
	input pong_pkg::coord_t paddle_x
);

	import pong_pkg::*;

	score_digits: assert property (@(posedge CLOCK_50_I) disable iff (!system_resetn)
		score.tens <= 4'd9 && score.ones <= 4'd9)
		else $error("score digit above 9");

	lives_left: assert property (@(posedge CLOCK_50_I) disable iff (!system_resetn)
		!game_over |-> lives != 2'd0)
		else $error("no lives left during play");

	// Ball frozen for the whole game over period
	ball_frozen: assert property (@(posedge CLOCK_50_I) disable iff (!system_resetn)
		game_over && $past(game_over) |-> $stable(ball))
		else $error("ball moved while the game is over");

	paddle_range: assert property (@(posedge CLOCK_50_I) disable iff (!system_resetn)
		paddle_x >= 10'd5 && paddle_x <= 10'd575)
		else $error("paddle outside its range");

endmodule

bind pong_core pong_core_properties i_pong_core_properties (.*);

// File: tests/pong_core_tb.sv
`timescale 1ns/1ps

module pong_core_tb;

	import pong_pkg::*;

	localparam int unsigned test_cps = 20; // Short seconds for simulation
	localparam int cycles_per_frame = 8;

	// One table row: inputs, frame count and expected outputs
	typedef struct packed {
		logic restart; // Row waits out the countdown instead of running frames
		logic move_right;
		logic move_left;
		speed_t speed;
		direction_t serve;
		logic [15:0] frames;
		object_pos_t ball;
		coord_t paddle_x;
		bcd2_t score;
		lives_t lives;
		logic game_over;
		bcd2_t high_score;
		bcd2_t high_game_id;
	} row_t;

	logic CLOCK_50_I, system_resetn, vsync, move_right, move_left, game_over;
	speed_t ball_speed;
	direction_t serve_dir;
	object_pos_t ball;
	coord_t paddle_x;
	bcd2_t score, high_score, high_game_id, time_left;
	lives_t lives;

	row_t table_q[$];
	object_pos_t m_ball; // Reference model state
	direction_t m_dir;
	int m_paddle, m_score, m_lives, m_hs, m_hid, m_gid;
	logic m_over;
	int cycles = 0;
	int limit = 0;
	int total_frames = 0;

	pong_core #(.clocks_per_second(test_cps)) i_pong_core (.*);

	initial begin
		CLOCK_50_I = 1'b0;
		forever #50 CLOCK_50_I = ~CLOCK_50_I;
	end

	always @(posedge CLOCK_50_I) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout: the run did not finish within %0d cycles", limit);
			$display(">>> FAIL");
			$fatal(1, "timeout");
		end
	end

	function automatic bcd2_t to_bcd(input int value);
		bcd2_t r;
		r.tens = 4'(value / 10);
		r.ones = 4'(value % 10);
		return r;
	endfunction

	task automatic stop_on_mismatch(input string msg);
		$display("mismatch at %0t ns: %s", $time, msg);
		$display(">>> FAIL");
		$fatal(1, "check failed");
	endtask

	task automatic check_pos(input object_pos_t got, input object_pos_t exp, input string what);
		if (got !== exp)
			stop_on_mismatch($sformatf("%s is (%0d,%0d), expected (%0d,%0d)",
				what, got.x, got.y, exp.x, exp.y));
	endtask

	task automatic check_coord(input coord_t got, input coord_t exp, input string what);
		if (got !== exp)
			stop_on_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
	endtask

	task automatic check_bcd(input bcd2_t got, input bcd2_t exp, input string what);
		if (got !== exp)
			stop_on_mismatch($sformatf("%s is %0d%0d, expected %0d%0d",
				what, got.tens, got.ones, exp.tens, exp.ones));
	endtask

	task automatic check_lives(input lives_t got, input lives_t exp, input string what);
		if (got !== exp)
			stop_on_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
			stop_on_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
	endtask

	// One frame of the game rules; hit test uses positions from before the step
	task automatic model_step(input logic mr, input logic ml, input int s, input direction_t sv);
		int x, y, ox, op;
		ox = m_ball.x;
		op = m_paddle;
		x = ox;
		y = m_ball.y;
		if (mr) begin
			if (m_paddle < 575) m_paddle += 5;
		end else if (ml && m_paddle > 5) begin
			m_paddle -= 5;
		end
		if (!m_over) begin
			if (m_dir.right) begin
				if (x + s <= 630) x += s;
				else m_dir.right = 1'b0;
			end else begin
				if (x >= s) x -= s;
				else m_dir.right = 1'b1;
			end
			if (!m_dir.down) begin
				if (y >= s) y -= s;
				else m_dir.down = 1'b1;
			end else if (y + s <= 415) begin
				y += s;
			end else if (ox >= op && ox + 10 <= op + 60) begin
				m_dir.down = 1'b0;
				m_score = (m_score + 1) % 100;
			end else begin
				x = 200; // Served again
				y = 50;
				m_dir = sv;
				if (m_lives == 1) begin
					m_over = 1'b1;
					if (m_score >= m_hs) begin
						m_hs = m_score;
						m_hid = m_gid;
					end
					m_gid = (m_gid + 1) % 100;
				end
				if (m_lives > 0) m_lives -= 1;
			end
			m_ball.x = coord_t'(x);
			m_ball.y = coord_t'(y);
		end
	endtask

	task automatic push_row(input logic rs, input logic mr, input logic ml, input int s,
		input direction_t sv, input int frames);
		row_t r;
		if (rs) begin
			m_score = 0;
			m_lives = 3;
			m_ball = '{x: 10'd200, y: 10'd50};
			m_dir = 2'b11;
			m_over = 1'b0;
		end else begin
			for (int i = 0; i < frames; i++) model_step(mr, ml, s, sv);
		end
		r = '{rs, mr, ml, speed_t'(s), sv, 16'(frames), m_ball, coord_t'(m_paddle),
			to_bcd(m_score), lives_t'(m_lives), m_over, to_bcd(m_hs), to_bcd(m_hid)};
		table_q.push_back(r);
		total_frames += frames;
	endtask

	// Paddle chases the ball centre
	task automatic add_tracking(input int s, input int n);
		int aim;
		repeat (n) begin
			aim = int'(m_ball.x) - 25;
			push_row(1'b0, m_paddle + 2 < aim, m_paddle > aim + 2, s, 2'b11, 1);
		end
	endtask

	// Paddle flees the ball until the last life is gone
	task automatic add_misses(input int s);
		logic left;
		direction_t sv;
		int guard;
		guard = 0;
		while (!m_over && guard < 3000) begin
			left = (int'(m_ball.x) + 5 >= m_paddle + 30);
			sv = (m_lives == 3) ? 2'b00 : (m_lives == 2) ? 2'b10 : 2'b01;
			push_row(1'b0, !left, left, s, sv, 1);
			guard++;
		end
	endtask

	task automatic run_frame();
		@(posedge CLOCK_50_I);
		vsync <= 1'b0;
		repeat (3) @(posedge CLOCK_50_I);
		vsync <= 1'b1;
		repeat (4) @(posedge CLOCK_50_I);
	endtask

	initial begin
		bcd2_t prev;
		system_resetn = 1'b0;
		vsync = 1'b1;
		move_right = 1'b0;
		move_left = 1'b0;
		ball_speed = 3'd1;
		serve_dir = 2'b11;
		m_ball = '{x: 10'd200, y: 10'd50};
		m_dir = 2'b11;
		m_paddle = 200;
		m_score = 0;
		m_lives = 3;
		m_hs = 0;
		m_hid = 0;
		m_gid = 1;
		m_over = 1'b0;

		push_row(1'b0, 1'b1, 1'b0, 1, 2'b11, 40); // Paddle walks right to its stop
		push_row(1'b0, 1'b1, 1'b0, 1, 2'b11, 40);
		push_row(1'b0, 1'b0, 1'b1, 1, 2'b11, 60); // Then left to the other stop
		push_row(1'b0, 1'b0, 1'b1, 1, 2'b11, 60);
		add_tracking(1, 80);
		add_tracking(3, 400);
		add_misses(7);
		push_row(1'b0, 1'b1, 1'b0, 7, 2'b11, 1); // Ball holds still during game over
		push_row(1'b1, 1'b0, 1'b0, 7, 2'b11, 0);
		add_misses(7); // Second game scores lower
		limit = 2 * (total_frames * cycles_per_frame + 20 * test_cps) + 16;

		repeat (8) @(posedge CLOCK_50_I);
		system_resetn <= 1'b1;
		@(negedge CLOCK_50_I);
		check_pos(ball, '{x: 10'd200, y: 10'd50}, "reset ball");
		check_coord(paddle_x, 10'd200, "reset paddle_x");
		check_bcd(score, 8'h00, "reset score");
		check_lives(lives, 2'd3, "reset lives");
		check_bcd(high_score, 8'h00, "reset high_score");
		check_bcd(high_game_id, 8'h00, "reset high_game_id");
		check_flag(game_over, 1'b0, "reset game_over");
		check_bcd(time_left, 8'h15, "reset time_left");

		foreach (table_q[i]) begin
			if (table_q[i].restart) begin
				check_flag(game_over, 1'b1, "game_over before countdown");
				for (int v = 14; v >= 0; v--) begin
					prev = time_left;
					while (time_left == prev) @(negedge CLOCK_50_I);
					check_bcd(time_left, to_bcd(v), "countdown time_left");
				end
				@(negedge CLOCK_50_I);
				check_bcd(time_left, 8'h15, "reloaded time_left");
			end else begin
				@(posedge CLOCK_50_I);
				move_right <= table_q[i].move_right;
				move_left <= table_q[i].move_left;
				ball_speed <= table_q[i].speed;
				serve_dir <= table_q[i].serve;
				repeat (table_q[i].frames) run_frame();
				@(negedge CLOCK_50_I);
			end
			check_pos(ball, table_q[i].ball, $sformatf("row %0d ball", i));
			check_coord(paddle_x, table_q[i].paddle_x, $sformatf("row %0d paddle_x", i));
			check_bcd(score, table_q[i].score, $sformatf("row %0d score", i));
			check_lives(lives, table_q[i].lives, $sformatf("row %0d lives", i));
			check_flag(game_over, table_q[i].game_over, $sformatf("row %0d game_over", i));
			check_bcd(high_score, table_q[i].high_score, $sformatf("row %0d high_score", i));
			check_bcd(high_game_id, table_q[i].high_game_id, $sformatf("row %0d game id", i));
		end
		$display(">>> PASS");
		$finish;
	end

endmodule
